// File: sim.f
src/periph_pkg.sv
src/obi_to_reg.sv
src/periph_addr_decode.sv
src/reg_demux.sv
src/soc_ctrl.sv
src/boot_rom.sv
src/uart_tx.sv
src/peripheral_subsystem.sv
testbench/tb_peripheral_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module tb_peripheral_subsystem -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^ALL CHECKS PASSED$" sim.log; then
  exit 0
fi
exit 1

// File: testbench/tb_peripheral_subsystem.sv
// Expected OBI responses are queued at grant time and compared on each rvalid beat
// The external slave model raises ready after a programmable number of cycles
`timescale 1ns/1ps

module tb_peripheral_subsystem;

  logic                  clk;
  logic                  arst_n;
  logic                  boot_select;
  periph_pkg::obi_req_t  obi_req;
  periph_pkg::obi_resp_t obi_resp;
  logic                  exit_valid;
  logic [31:0]           exit_value;
  logic                  uart_tx;
  logic                  uart_tx_done;
  periph_pkg::reg_req_t  ext_req;
  periph_pkg::reg_rsp_t  ext_rsp;

  int          seed = 48;
  int          done_count = 0;
  string       exp_name_q [$];
  logic [31:0] exp_rdata_q [$];
  logic        exp_err_q [$];
  string       chk_name;
  logic [31:0] chk_rdata;
  logic        chk_err;
  logic        ext_pending_q = 1'b0;
  int          ext_delay;
  int          ext_cnt;
  logic [31:0] ext_data;
  logic [31:0] ext_addr;

  peripheral_subsystem dut_i (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .boot_select_i  (boot_select),
    .obi_req_i      (obi_req),
    .obi_resp_o     (obi_resp),
    .exit_valid_o   (exit_valid),
    .exit_value_o   (exit_value),
    .uart_tx_o      (uart_tx),
    .uart_tx_done_o (uart_tx_done),
    .ext_req_o      (ext_req),
    .ext_rsp_i      (ext_rsp)
  );

  always #2 clk = ~clk;

  task automatic stop_on_failure(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    stop_on_failure($sformatf("error %s expected 0x%h actual 0x%h", name, exp, act));
  endtask

  function automatic logic [31:0] target_addr(input int idx, input logic [11:0] ofs);
    return periph_pkg::TARGET_BASE[idx] + {20'h0, ofs};
  endfunction

  // Byte lanes with a set strobe take the new data
  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                              input logic [3:0] be);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = wdata[8*b +: 8];
    end
    return res;
  endfunction

  // Called on a falling edge, returns on the falling edge after the grant
  task automatic obi_access(input string name, input logic we, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] be,
                            input logic [31:0] exp_rdata, input logic exp_err);
    int waited;
    waited = 0;
    obi_req.req   = 1'b1;
    obi_req.we    = we;
    obi_req.be    = be;
    obi_req.addr  = addr;
    obi_req.wdata = wdata;
    @(posedge clk);
    while (!obi_resp.gnt) begin
      waited++;
      if (waited > 50) stop_on_failure($sformatf("no grant for %s after 50 cycles", name));
      @(posedge clk);
    end
    exp_name_q.push_back(name);
    exp_rdata_q.push_back(we ? 32'h0 : exp_rdata);
    exp_err_q.push_back(exp_err);
    @(negedge clk);
    obi_req = '0;
  endtask

  task automatic write_reg(input string name, input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] be, input logic exp_err);
    obi_access(name, 1'b1, addr, wdata, be, 32'h0, exp_err);
  endtask

  task automatic read_reg(input string name, input logic [31:0] addr,
                          input logic [31:0] exp_rdata, input logic exp_err);
    obi_access(name, 1'b0, addr, 32'h0, 4'hF, exp_rdata, exp_err);
  endtask

  // Samples the line in the middle of each bit, starting from the falling start edge
  task automatic uart_monitor(input int div, input logic [7:0] exp_byte);
    int         waited;
    logic [7:0] got;
    waited = 0;
    while (uart_tx === 1'b1) begin
      @(negedge clk);
      waited++;
      if (waited > 100) stop_on_failure("UART start bit did not appear");
    end
    repeat ((div - 1) / 2) @(negedge clk);
    assert (uart_tx == 1'b0) else report_mismatch("uart_start", 32'h0, 32'(uart_tx));
    for (int i = 0; i < 8; i++) begin
      repeat (div) @(negedge clk);
      got[i] = uart_tx;
    end
    assert (got == exp_byte) else report_mismatch("uart_data", 32'(exp_byte), 32'(got));
    repeat (div) @(negedge clk);
    assert (uart_tx == 1'b1) else report_mismatch("uart_stop", 32'h1, 32'(uart_tx));
  endtask

  // Response checker
  always @(negedge clk) begin
    if (arst_n && obi_resp.rvalid) begin
      if (exp_rdata_q.size() == 0) begin
        stop_on_failure("rvalid arrived with no outstanding request");
      end else begin
        chk_name  = exp_name_q.pop_front();
        chk_rdata = exp_rdata_q.pop_front();
        chk_err   = exp_err_q.pop_front();
        assert (obi_resp.err == chk_err)
          else report_mismatch({chk_name, "_err"}, 32'(chk_err), 32'(obi_resp.err));
        assert (obi_resp.rdata == chk_rdata)
          else report_mismatch(chk_name, chk_rdata, obi_resp.rdata);
      end
    end
    if (uart_tx_done) done_count++;
  end

  // External slave, ready rises ext_delay cycles after the request is seen
  always @(posedge clk) ext_pending_q <= ext_req.valid & ~ext_rsp.ready;

  always @(negedge clk) begin
    if (ext_rsp.ready) begin
      ext_rsp.ready <= 1'b0;
      ext_cnt       <= 0;
    end else if (ext_pending_q) begin
      if (ext_cnt >= ext_delay) begin
        ext_rsp.ready <= 1'b1;
        ext_rsp.rdata <= ext_data;
      end else begin
        ext_cnt <= ext_cnt + 1;
      end
    end
  end

  a_gnt_then_rvalid : assert property (@(posedge clk) disable iff (!arst_n)
    obi_resp.gnt |=> obi_resp.rvalid) else stop_on_failure("grant not followed by rvalid");
  a_rvalid_after_gnt : assert property (@(posedge clk) disable iff (!arst_n)
    obi_resp.rvalid |-> $past(obi_resp.gnt)) else stop_on_failure("rvalid without a grant");
  a_ext_backpressure : assert property (@(posedge clk) disable iff (!arst_n)
    (ext_req.valid && !ext_rsp.ready) |-> !obi_resp.gnt)
    else stop_on_failure("grant given while the external port was not ready");
  a_ext_addr : assert property (@(posedge clk) disable iff (!arst_n)
    ext_req.valid |-> (ext_req.addr == ext_addr))
    else report_mismatch("ext_addr", ext_addr, ext_req.addr);
  a_ext_read : assert property (@(posedge clk) disable iff (!arst_n)
    ext_req.valid |-> !ext_req.write)
    else report_mismatch("ext_write", 32'h0, 32'(ext_req.write));
  a_done_single : assert property (@(posedge clk) disable iff (!arst_n)
    uart_tx_done |=> !uart_tx_done) else stop_on_failure("UART done pulse longer than a cycle");

  initial begin
    logic [31:0] scratch_a;
    logic [31:0] scratch_b;
    logic [3:0]  scratch_be;
    logic [31:0] exit_val;
    logic [7:0]  tx_byte;
    int          div;
    int          waited;
    clk         = 1'b0;
    arst_n      = 1'b0;
    boot_select = 1'b0;
    obi_req     = '0;
    ext_rsp     = '0;
    ext_cnt     = 0;
    ext_delay   = 0;
    ext_data    = 32'h0;
    ext_addr    = 32'h0;
    repeat (5) @(negedge clk);
    arst_n = 1'b1;

    assert (!obi_resp.gnt && !obi_resp.rvalid)
      else stop_on_failure("OBI strobes high after reset");
    assert (!exit_valid) else report_mismatch("reset_exit_valid", 32'h0, 32'(exit_valid));
    assert (exit_value == 32'h0) else report_mismatch("reset_exit_value", 32'h0, exit_value);
    assert (!uart_tx_done) else report_mismatch("reset_tx_done", 32'h0, 32'(uart_tx_done));
    assert (uart_tx) else report_mismatch("reset_tx_line", 32'h1, 32'(uart_tx));

    for (int i = 0; i < periph_pkg::BOOT_ROM_DEPTH; i++) begin
      read_reg("rom_read", target_addr(periph_pkg::BOOTROM_IDX, 12'(4 * i)),
               periph_pkg::BOOT_ROM_WORDS[i], 1'b0);
    end
    read_reg("rom_beyond", target_addr(periph_pkg::BOOTROM_IDX, 12'h040), 32'h0, 1'b0);
    write_reg("rom_write", target_addr(periph_pkg::BOOTROM_IDX, 12'h0), 32'h1234_5678,
              4'hF, 1'b1);

    scratch_a  = $random(seed);
    scratch_b  = $random(seed);
    scratch_be = 4'($random(seed));
    write_reg("scratch_full", target_addr(periph_pkg::SOC_CTRL_IDX, periph_pkg::SCRATCH_OFS),
              scratch_a, 4'hF, 1'b0);
    write_reg("scratch_part", target_addr(periph_pkg::SOC_CTRL_IDX, periph_pkg::SCRATCH_OFS),
              scratch_b, scratch_be, 1'b0);
    read_reg("scratch_read", target_addr(periph_pkg::SOC_CTRL_IDX, periph_pkg::SCRATCH_OFS),
             merge_bytes(scratch_a, scratch_b, scratch_be), 1'b0);
    boot_select = 1'b1;
    @(negedge clk);
    read_reg("boot_sel_1", target_addr(periph_pkg::SOC_CTRL_IDX, periph_pkg::BOOT_SEL_OFS),
             32'h1, 1'b0);
    boot_select = 1'b0;
    @(negedge clk);
    read_reg("boot_sel_0", target_addr(periph_pkg::SOC_CTRL_IDX, periph_pkg::BOOT_SEL_OFS),
             32'h0, 1'b0);
    exit_val = $random(seed);
    write_reg("exit_value", target_addr(periph_pkg::SOC_CTRL_IDX, periph_pkg::EXIT_VALUE_OFS),
              exit_val, 4'hF, 1'b0);
    write_reg("exit_valid", target_addr(periph_pkg::SOC_CTRL_IDX, periph_pkg::EXIT_VALID_OFS),
              32'h1, 4'hF, 1'b0);
    assert (exit_valid) else report_mismatch("exit_valid_pin", 32'h1, 32'(exit_valid));
    assert (exit_value == exit_val) else report_mismatch("exit_value_pin", exit_val, exit_value);

    read_reg("unmapped", 32'h1000_0000, 32'h0, 1'b1);
    for (int i = 0; i < 2; i++) begin
      ext_delay = $unsigned($random(seed)) % 6;
      ext_data  = $random(seed);
      ext_addr  = target_addr(periph_pkg::EXT_PERIPH_IDX, 12'(8 * i));
      read_reg("ext_read", ext_addr, ext_data, 1'b0);
    end

    div     = 2 + $unsigned($random(seed)) % 7;
    tx_byte = 8'($random(seed));
    write_reg("uart_div", target_addr(periph_pkg::UART_IDX, periph_pkg::UART_DIV_OFS),
              32'(div), 4'hF, 1'b0);
    read_reg("uart_div_read", target_addr(periph_pkg::UART_IDX, periph_pkg::UART_DIV_OFS),
             32'(div), 1'b0);
    fork
      uart_monitor(div, tx_byte);
      begin
        write_reg("uart_txdata", target_addr(periph_pkg::UART_IDX, periph_pkg::UART_TXDATA_OFS),
                  {24'h0, tx_byte}, 4'h1, 1'b0);
        read_reg("uart_busy", target_addr(periph_pkg::UART_IDX, periph_pkg::UART_STATUS_OFS),
                 32'h1, 1'b0);
        // Dropped while the frame is running
        write_reg("uart_txdata_busy",
                  target_addr(periph_pkg::UART_IDX, periph_pkg::UART_TXDATA_OFS),
                  {24'h0, ~tx_byte}, 4'h1, 1'b0);
      end
    join
    waited = 0;
    while (done_count == 0) begin
      @(negedge clk);
      waited++;
      if (waited > 4 * div) stop_on_failure("UART done pulse did not appear after the frame");
    end
    repeat (3) @(negedge clk);
    read_reg("uart_idle", target_addr(periph_pkg::UART_IDX, periph_pkg::UART_STATUS_OFS),
             32'h0, 1'b0);
    assert (done_count == 1) else report_mismatch("uart_done_count", 32'h1, 32'(done_count));

    waited = 0;
    while (exp_rdata_q.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > 20) stop_on_failure("outstanding responses never arrived");
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: src/peripheral_subsystem.sv
// Peripheral subsystem top: OBI bridge, address decode, demux and targets
// The external port may stall with ready low, internal targets answer at once
`timescale 1ns/1ps

module peripheral_subsystem (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  boot_select_i,
  input  periph_pkg::obi_req_t  obi_req_i,
  output periph_pkg::obi_resp_t obi_resp_o,
  output logic                  exit_valid_o,
  output logic [31:0]           exit_value_o,
  output logic                  uart_tx_o,
  output logic                  uart_tx_done_o,
  output periph_pkg::reg_req_t  ext_req_o,
  input  periph_pkg::reg_rsp_t  ext_rsp_i
);

  periph_pkg::reg_req_t periph_req;
  periph_pkg::reg_rsp_t periph_rsp;

  periph_pkg::reg_req_t [periph_pkg::NUM_TARGETS-1:0] slv_req;
  periph_pkg::reg_rsp_t [periph_pkg::NUM_TARGETS-1:0] slv_rsp;

  logic [periph_pkg::TARGET_SEL_W-1:0] periph_sel;
  logic                                periph_unmapped;

  assign ext_req_o                           = slv_req[periph_pkg::EXT_PERIPH_IDX];
  assign slv_rsp[periph_pkg::EXT_PERIPH_IDX] = ext_rsp_i;

  obi_to_reg obi_to_reg_i (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .obi_req_i  (obi_req_i),
    .obi_resp_o (obi_resp_o),
    .reg_req_o  (periph_req),
    .reg_rsp_i  (periph_rsp)
  );

  periph_addr_decode periph_addr_decode_i (
    .addr_i     (periph_req.addr),
    .sel_o      (periph_sel),
    .unmapped_o (periph_unmapped)
  );

  reg_demux reg_demux_i (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .sel_i      (periph_sel),
    .unmapped_i (periph_unmapped),
    .in_req_i   (periph_req),
    .in_rsp_o   (periph_rsp),
    .out_req_o  (slv_req),
    .out_rsp_i  (slv_rsp)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .boot_select_i (boot_select_i),
    .reg_req_i     (slv_req[periph_pkg::SOC_CTRL_IDX]),
    .reg_rsp_o     (slv_rsp[periph_pkg::SOC_CTRL_IDX]),
    .exit_valid_o  (exit_valid_o),
    .exit_value_o  (exit_value_o)
  );

  boot_rom boot_rom_i (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .reg_req_i (slv_req[periph_pkg::BOOTROM_IDX]),
    .reg_rsp_o (slv_rsp[periph_pkg::BOOTROM_IDX])
  );

  uart_tx uart_tx_i (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .reg_req_i      (slv_req[periph_pkg::UART_IDX]),
    .reg_rsp_o      (slv_rsp[periph_pkg::UART_IDX]),
    .uart_tx_o      (uart_tx_o),
    .uart_tx_done_o (uart_tx_done_o)
  );

endmodule

// File: src/uart_tx.sv
// UART transmitter, 8N1, no FIFO
// A TXDATA write while a frame is running is dropped, poll STATUS bit 0 first
// Divisor 0 behaves like 1
`timescale 1ns/1ps

module uart_tx (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  periph_pkg::reg_req_t reg_req_i,
  output periph_pkg::reg_rsp_t reg_rsp_o,
  output logic                 uart_tx_o,
  output logic                 uart_tx_done_o
);

  logic [11:0] ofs;
  logic        wr;
  logic        ofs_known;
  logic        txdata_wr;
  logic        div_wr;
  logic        busy_q;
  logic        done_q;
  logic [9:0]  shift_q;
  logic [3:0]  bit_cnt_q;
  logic [15:0] baud_cnt_q;
  logic [15:0] div_q;

  assign ofs       = reg_req_i.addr[11:0];
  assign wr        = reg_req_i.valid & reg_req_i.write;
  assign ofs_known = (ofs == periph_pkg::UART_TXDATA_OFS) |
                     (ofs == periph_pkg::UART_STATUS_OFS) |
                     (ofs == periph_pkg::UART_DIV_OFS);
  assign txdata_wr = wr & (ofs == periph_pkg::UART_TXDATA_OFS) & reg_req_i.wstrb[0];
  assign div_wr    = wr & (ofs == periph_pkg::UART_DIV_OFS);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
      shift_q    <= '1;
      bit_cnt_q  <= 4'd0;
      baud_cnt_q <= 16'd0;
      div_q      <= periph_pkg::UART_DIV_RESET;
    end else begin
      done_q <= 1'b0;
      if (div_wr && reg_req_i.wstrb[0]) div_q[7:0] <= reg_req_i.wdata[7:0];
      if (div_wr && reg_req_i.wstrb[1]) div_q[15:8] <= reg_req_i.wdata[15:8];
      if (!busy_q) begin
        if (txdata_wr) begin
          // Stop, data LSB first, start
          shift_q    <= {1'b1, reg_req_i.wdata[7:0], 1'b0};
          busy_q     <= 1'b1;
          bit_cnt_q  <= 4'd0;
          baud_cnt_q <= 16'd0;
        end
      end else if (baud_cnt_q + 16'd1 >= div_q) begin
        baud_cnt_q <= 16'd0;
        shift_q    <= {1'b1, shift_q[9:1]};
        if (bit_cnt_q == 4'd9) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end else begin
          bit_cnt_q <= bit_cnt_q + 4'd1;
        end
      end else begin
        baud_cnt_q <= baud_cnt_q + 16'd1;
      end
    end
  end

  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = reg_req_i.valid &
                      (~ofs_known | (reg_req_i.write & ofs == periph_pkg::UART_STATUS_OFS));
    if (ofs == periph_pkg::UART_STATUS_OFS) begin
      reg_rsp_o.rdata = {31'h0, busy_q};
    end else if (ofs == periph_pkg::UART_DIV_OFS) begin
      reg_rsp_o.rdata = {16'h0, div_q};
    end else begin
      reg_rsp_o.rdata = 32'h0;
    end
  end

  // Line idles high
  assign uart_tx_o      = busy_q ? shift_q[0] : 1'b1;
  assign uart_tx_done_o = done_q;

  a_idle_high : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    !busy_q |-> uart_tx_o
  ) else $error("tx line low while idle");

endmodule

// File: src/boot_rom.sv
// Boot ROM, 16 words from the package image at the bottom of its window
// Reads above 0x3C return zero, every write is refused with an error
`timescale 1ns/1ps

module boot_rom (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  periph_pkg::reg_req_t reg_req_i,
  output periph_pkg::reg_rsp_t reg_rsp_o
);

  logic [11:0] ofs;
  logic [3:0]  word_idx;
  logic        in_rom;

  assign ofs      = reg_req_i.addr[11:0];
  assign word_idx = reg_req_i.addr[5:2];
  assign in_rom   = ofs < 12'h040;

  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = reg_req_i.valid & reg_req_i.write;
    if (in_rom && !reg_req_i.write) begin
      reg_rsp_o.rdata = periph_pkg::BOOT_ROM_WORDS[word_idx];
    end else begin
      reg_rsp_o.rdata = 32'h0;
    end
  end

  a_ready_needs_valid : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    reg_rsp_o.ready |-> reg_req_i.valid
  ) else $error("boot ROM ready without a request");

endmodule

// File: src/soc_ctrl.sv
// SoC control registers, single-cycle register bus target
// boot_select_i is sampled once per cycle, BOOT_SEL is read only
`timescale 1ns/1ps

module soc_ctrl (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 boot_select_i,
  input  periph_pkg::reg_req_t reg_req_i,
  output periph_pkg::reg_rsp_t reg_rsp_o,
  output logic                 exit_valid_o,
  output logic [31:0]          exit_value_o
);

  logic [11:0] ofs;
  logic        wr;
  logic        ofs_known;
  logic        exit_valid_q;
  logic [31:0] exit_value_q;
  logic [31:0] scratch_q;
  logic        boot_sel_q;

  assign ofs = reg_req_i.addr[11:0];
  assign wr  = reg_req_i.valid & reg_req_i.write;

  assign ofs_known = (ofs == periph_pkg::EXIT_VALID_OFS) |
                     (ofs == periph_pkg::EXIT_VALUE_OFS) |
                     (ofs == periph_pkg::BOOT_SEL_OFS) |
                     (ofs == periph_pkg::SCRATCH_OFS);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= 32'h0;
      boot_sel_q   <= 1'b0;
    end else begin
      boot_sel_q <= boot_select_i;
      if (wr && ofs == periph_pkg::EXIT_VALID_OFS && reg_req_i.wstrb[0]) begin
        exit_valid_q <= reg_req_i.wdata[0];
      end
      if (wr && ofs == periph_pkg::EXIT_VALUE_OFS) begin
        for (int b = 0; b < 4; b++) begin
          if (reg_req_i.wstrb[b]) exit_value_q[8*b +: 8] <= reg_req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr && ofs == periph_pkg::SCRATCH_OFS) begin
      for (int b = 0; b < 4; b++) begin
        if (reg_req_i.wstrb[b]) scratch_q[8*b +: 8] <= reg_req_i.wdata[8*b +: 8];
      end
    end
  end

  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = reg_req_i.valid &
                      (~ofs_known | (reg_req_i.write & ofs == periph_pkg::BOOT_SEL_OFS));
    unique case (ofs)
      periph_pkg::EXIT_VALID_OFS: reg_rsp_o.rdata = {31'h0, exit_valid_q};
      periph_pkg::EXIT_VALUE_OFS: reg_rsp_o.rdata = exit_value_q;
      periph_pkg::BOOT_SEL_OFS:   reg_rsp_o.rdata = {31'h0, boot_sel_q};
      periph_pkg::SCRATCH_OFS:    reg_rsp_o.rdata = scratch_q;
      default:                    reg_rsp_o.rdata = 32'h0;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule

// File: src/reg_demux.sv
// Register bus demux, forwards valid to one target only
// Unmapped accesses are answered here with an error and zero data
`timescale 1ns/1ps

module reg_demux (
  input  logic                                    clk_i,
  input  logic                                    arst_n_i,
  input  logic [periph_pkg::TARGET_SEL_W-1:0]      sel_i,
  input  logic                                    unmapped_i,
  input  periph_pkg::reg_req_t                     in_req_i,
  output periph_pkg::reg_rsp_t                     in_rsp_o,
  output periph_pkg::reg_req_t [periph_pkg::NUM_TARGETS-1:0] out_req_o,
  input  periph_pkg::reg_rsp_t [periph_pkg::NUM_TARGETS-1:0] out_rsp_i
);

  logic [periph_pkg::NUM_TARGETS-1:0] out_valid;

  always_comb begin
    for (int i = 0; i < periph_pkg::NUM_TARGETS; i++) begin
      out_req_o[i]       = in_req_i;
      out_req_o[i].valid = in_req_i.valid & ~unmapped_i &
                           (sel_i == i[periph_pkg::TARGET_SEL_W-1:0]);
      out_valid[i]       = out_req_o[i].valid;
    end
  end

  always_comb begin
    if (unmapped_i) begin
      in_rsp_o.ready = in_req_i.valid;
      in_rsp_o.error = 1'b1;
      in_rsp_o.rdata = 32'h0;
    end else begin
      in_rsp_o = out_rsp_i[sel_i];
    end
  end

  a_onehot_valid : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(out_valid)
  ) else $error("more than one target selected");

endmodule

// File: src/periph_addr_decode.sv
// Combinational address decode against the base/span table
// Windows must not overlap, the last match wins otherwise
`timescale 1ns/1ps

module periph_addr_decode (
  input  logic [31:0]                       addr_i,
  output logic [periph_pkg::TARGET_SEL_W-1:0] sel_o,
  output logic                              unmapped_o
);

  logic hit;

  always_comb begin
    hit   = 1'b0;
    sel_o = '0;
    for (int i = 0; i < periph_pkg::NUM_TARGETS; i++) begin
      if (addr_i >= periph_pkg::TARGET_BASE[i] &&
          addr_i < periph_pkg::TARGET_BASE[i] + periph_pkg::TARGET_SPAN) begin
        hit   = 1'b1;
        sel_o = i[periph_pkg::TARGET_SEL_W-1:0];
      end
    end
  end

  // Nothing in the map claims this address
  assign unmapped_o = ~hit;

endmodule

// File: src/obi_to_reg.sv
// OBI slave to register bus bridge, one transfer in flight
// The master must hold req and its fields stable until gnt
`timescale 1ns/1ps

module obi_to_reg (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  periph_pkg::obi_req_t  obi_req_i,
  output periph_pkg::obi_resp_t obi_resp_o,
  output periph_pkg::reg_req_t  reg_req_o,
  input  periph_pkg::reg_rsp_t  reg_rsp_i
);

  logic        gnt;
  logic        rvalid_q;
  logic        err_q;
  logic [31:0] rdata_q;

  assign reg_req_o.valid = obi_req_i.req;
  assign reg_req_o.write = obi_req_i.we;
  assign reg_req_o.wstrb = obi_req_i.be;
  assign reg_req_o.addr  = obi_req_i.addr;
  assign reg_req_o.wdata = obi_req_i.wdata;

  // Grant as soon as the addressed target is ready
  assign gnt = obi_req_i.req & reg_rsp_i.ready;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= gnt;
    end
  end

  // Response beat, writes return zero data
  always_ff @(posedge clk_i) begin
    if (gnt) begin
      err_q   <= reg_rsp_i.error;
      rdata_q <= obi_req_i.we ? 32'h0 : reg_rsp_i.rdata;
    end
  end

  assign obi_resp_o.gnt    = gnt;
  assign obi_resp_o.rvalid = rvalid_q;
  assign obi_resp_o.err    = err_q;
  assign obi_resp_o.rdata  = rdata_q;

  a_rvalid_after_gnt : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    obi_resp_o.rvalid |-> $past(obi_resp_o.gnt)
  ) else $error("rvalid without a grant in the previous cycle");

endmodule

// File: src/periph_pkg.sv
// Shared bus types, address map and boot ROM image for the peripheral subsystem
// Each target owns a 4 KiB window, and only address bits 11:0 reach its register decode
package periph_pkg;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } obi_resp_t;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [3:0]  wstrb;
    logic [31:0] addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic        ready;
    logic        error;
    logic [31:0] rdata;
  } reg_rsp_t;

  localparam int NUM_TARGETS  = 4;
  localparam int TARGET_SEL_W = 2;

  localparam int SOC_CTRL_IDX   = 0;
  localparam int BOOTROM_IDX    = 1;
  localparam int UART_IDX       = 2;
  localparam int EXT_PERIPH_IDX = 3;

  localparam logic [31:0] TARGET_BASE [NUM_TARGETS] = '{
    32'h2000_0000, 32'h2000_1000, 32'h2000_2000, 32'h2000_3000
  };
  localparam logic [31:0] TARGET_SPAN = 32'h0000_1000;

  localparam logic [11:0] EXIT_VALID_OFS = 12'h000;
  localparam logic [11:0] EXIT_VALUE_OFS = 12'h004;
  localparam logic [11:0] BOOT_SEL_OFS   = 12'h008;
  localparam logic [11:0] SCRATCH_OFS    = 12'h00C;

  localparam logic [11:0] UART_TXDATA_OFS = 12'h000;
  localparam logic [11:0] UART_STATUS_OFS = 12'h004;
  localparam logic [11:0] UART_DIV_OFS    = 12'h008;

  localparam logic [15:0] UART_DIV_RESET = 16'd4;

  // Small RV32I stub, parks the hart in a wfi loop
  localparam int BOOT_ROM_DEPTH = 16;
  localparam logic [31:0] BOOT_ROM_WORDS [BOOT_ROM_DEPTH] = '{
    32'h2000_02B7, 32'h0002_A303, 32'h0003_0663, 32'h1000_0537, 32'h0005_0067,
    32'h0000_0013, 32'h1050_0073, 32'hFF9F_F06F, 32'h0000_0013, 32'h0000_0013,
    32'h0000_0013, 32'h0000_0013, 32'h0000_0013, 32'h0000_0013, 32'hDEAD_BEEF,
    32'hB007_0001
  };

endpackage
